// ==== verilog/riscv_core_pkg.sv ====
// Shared RV32M types and constants; XLEN is fixed at 32 and the latencies are not configurable

package riscv_core_pkg;

    ////////////////////
    // Data width
    ////////////////////

    // Width of one integer register
    localparam int unsigned XLEN = 32;

    // Operand and result word
    typedef logic [XLEN-1:0] word_t;

    ////////////////////
    // Operation codes
    ////////////////////

    // funct3 of the OP major opcode with funct7 = 0000001
    // Bit 2 picks divide over multiply
    // For divides, bit 1 picks remainder and bit 0 picks unsigned
    typedef enum logic [2:0] {
        MD_MUL    = 3'd0,
        MD_MULH   = 3'd1,
        MD_MULHSU = 3'd2,
        MD_MULHU  = 3'd3,
        MD_DIV    = 3'd4,
        MD_DIVU   = 3'd5,
        MD_REM    = 3'd6,
        MD_REMU   = 3'd7
    } md_op_e;

    ////////////////////
    // Latencies
    ////////////////////

    // Cycles from start to done for any multiply
    // Operand register, then product register
    localparam int unsigned MUL_LATENCY = 2;

    // Cycles from an accepted start to done for any divide
    // One load cycle plus one restoring step per result bit
    // Special cases take the same time
    localparam int unsigned DIV_LATENCY = XLEN + 1;

endpackage : riscv_core_pkg

// ==== verilog/mult_unit.sv ====
// Two-stage RV32M multiplier; a new start is taken every cycle and no start is ever refused

`timescale 1ns/1ps

module mult_unit
    import riscv_core_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,

    // One-cycle request pulse
    input  logic       start_i,
    input  word_t      operand_a_i,
    input  word_t      operand_b_i,
    // funct3[1:0] of the multiply
    input  logic [1:0] op_type_i,

    output word_t      result_o,
    output logic       done_o
);

    ////////////////////
    // Stage 1
    ////////////////////

    word_t      operand_a_q;
    word_t      operand_b_q;
    logic [1:0] op_type_q;
    logic       valid_s1_q;

    // Operands only move on a start
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            operand_a_q <= operand_a_i;
            operand_b_q <= operand_b_i;
            op_type_q   <= op_type_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_s1_q <= 1'b0;
        end else begin
            valid_s1_q <= start_i;
        end
    end

    ////////////////////
    // Stage 2
    ////////////////////

    logic signed [63:0] product_ss;
    logic signed [63:0] product_su;
    logic        [63:0] product_uu;
    word_t              product_sel;
    word_t              result_q;
    logic               valid_s2_q;

    // Three full products, left to synthesis to share
    assign product_ss = $signed(operand_a_q) * $signed(operand_b_q);
    // Zero-extend b so it stays positive in a signed multiply
    assign product_su = $signed(operand_a_q) * $signed({1'b0, operand_b_q});
    assign product_uu = operand_a_q * operand_b_q;

    // Pick the half that the operation returns
    always_comb begin
        case (md_op_e'({1'b0, op_type_q}))
            MD_MULH:   product_sel = product_ss[63:32];
            MD_MULHSU: product_sel = product_su[63:32];
            MD_MULHU:  product_sel = product_uu[63:32];
            // MUL: low half is the same for any signedness
            default:   product_sel = product_uu[31:0];
        endcase
    end

    // Result holds between multiplies
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            result_q   <= '0;
            valid_s2_q <= 1'b0;
        end else begin
            valid_s2_q <= valid_s1_q;
            if (valid_s1_q) begin
                result_q <= product_sel;
            end
        end
    end

    assign result_o = result_q;
    assign done_o   = valid_s2_q;

endmodule : mult_unit

// ==== verilog/div_unit.sv ====
// Radix-2 restoring RV32M divider; one divide at a time and starts while busy are dropped

`timescale 1ns/1ps

module div_unit
    import riscv_core_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,

    // One-cycle request, taken only when idle
    input  logic       start_i,
    // Dividend
    input  word_t      operand_a_i,
    // Divisor
    input  word_t      operand_b_i,
    // Bit 0 unsigned, bit 1 remainder
    input  logic [1:0] op_type_i,

    output word_t      result_o,
    output logic       done_o,
    output logic       busy_o
);

    typedef enum logic [1:0] {
        IDLE,
        CALC,
        FINISH
    } div_state_e;

    div_state_e state_q;
    logic [5:0] cnt_q;
    word_t      result_q;

    // Datapath registers
    logic [XLEN-1:0] rem_q;
    word_t           quo_q;
    word_t           divisor_q;
    word_t           dividend_q;
    logic            rem_sel_q;
    logic            quo_neg_q;
    logic            rem_neg_q;
    logic            div_zero_q;
    logic            ovf_q;

    logic  start_acc;
    logic  last_step;
    logic  op_signed;
    logic  a_neg;
    logic  b_neg;
    word_t a_abs;
    word_t b_abs;

    assign start_acc = start_i && (state_q == IDLE);
    // Counter runs 0..31, so step 32 is the one at count 31
    assign last_step = (cnt_q == 6'(DIV_LATENCY - 2));

    ////////////////////
    // Operand prep
    ////////////////////

    assign op_signed = ~op_type_i[0];
    assign a_neg     = op_signed & operand_a_i[XLEN-1];
    assign b_neg     = op_signed & operand_b_i[XLEN-1];
    // Most negative value maps to itself, still right as a magnitude
    assign a_abs     = a_neg ? -operand_a_i : operand_a_i;
    assign b_abs     = b_neg ? -operand_b_i : operand_b_i;

    ////////////////////
    // One restoring step
    ////////////////////

    logic [XLEN:0]   rem_shift;
    logic [XLEN:0]   diff;
    logic [XLEN-1:0] rem_next;
    word_t           quo_next;

    // Bring in the next dividend bit, then try the subtract
    assign rem_shift = {rem_q, quo_q[XLEN-1]};
    assign diff      = rem_shift - {1'b0, divisor_q};

    always_comb begin
        if (!diff[XLEN]) begin
            // No borrow, keep the difference
            rem_next = diff[XLEN-1:0];
            quo_next = {quo_q[XLEN-2:0], 1'b1};
        end else begin
            // Borrow, restore
            rem_next = rem_shift[XLEN-1:0];
            quo_next = {quo_q[XLEN-2:0], 1'b0};
        end
    end

    ////////////////////
    // Fix-up
    ////////////////////

    word_t quo_fix;
    word_t rem_fix;
    word_t result_fix;

    always_comb begin
        quo_fix = quo_neg_q ? -quo_next : quo_next;
        rem_fix = rem_neg_q ? -rem_next : rem_next;
        // RISC-V divide by zero
        if (div_zero_q) begin
            quo_fix = '1;
            rem_fix = dividend_q;
        // Signed overflow, most negative by minus one
        end else if (ovf_q) begin
            quo_fix = dividend_q;
            rem_fix = '0;
        end
        result_fix = rem_sel_q ? rem_fix : quo_fix;
    end

    ////////////////////
    // Datapath
    ////////////////////

    always_ff @(posedge clk_i) begin
        if (start_acc) begin
            rem_q      <= '0;
            quo_q      <= a_abs;
            divisor_q  <= b_abs;
            dividend_q <= operand_a_i;
            rem_sel_q  <= op_type_i[1];
            // Quotient sign from both operands, remainder sign follows the dividend
            quo_neg_q  <= a_neg ^ b_neg;
            rem_neg_q  <= a_neg;
            div_zero_q <= (operand_b_i == '0);
            ovf_q      <= op_signed &&
                          (operand_a_i == {1'b1, {(XLEN-1){1'b0}}}) &&
                          (operand_b_i == '1);
        end else if (state_q == CALC) begin
            rem_q <= rem_next;
            quo_q <= quo_next;
        end
    end

    ////////////////////
    // Control FSM
    ////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q  <= IDLE;
            cnt_q    <= '0;
            result_q <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        state_q <= CALC;
                        cnt_q   <= '0;
                    end
                end
                CALC: begin
                    cnt_q <= cnt_q + 6'd1;
                    // Signed result lands with the last step
                    if (last_step) begin
                        state_q  <= FINISH;
                        result_q <= result_fix;
                    end
                end
                // Done cycle, back to idle next
                FINISH:  state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    assign result_o = result_q;
    assign done_o   = (state_q == FINISH);
    assign busy_o   = (state_q != IDLE);

endmodule : div_unit

// ==== verilog/muldiv_unit.sv ====
// RV32M execute top; no back-pressure, each result must be taken in its done cycle

`timescale 1ns/1ps

module muldiv_unit
    import riscv_core_pkg::*;
(
    input  logic   clk_i,
    input  logic   rst_ni,

    // One-cycle request, ignored while busy
    input  logic   start_i,
    input  md_op_e funct3_i,
    input  word_t  operand_a_i,
    input  word_t  operand_b_i,

    // Valid only while done_o is high
    output word_t  result_o,
    output logic   done_o,
    output logic   busy_o
);

    logic  mult_start;
    logic  div_start;
    logic  mult_done;
    logic  div_done;
    logic  div_busy;
    word_t mult_result;
    word_t div_result;
    logic  last_div_q;

    ////////////////////
    // Dispatch
    ////////////////////

    // Multiplies wait out a running divide
    assign mult_start = start_i & ~funct3_i[2] & ~div_busy;
    // Divider drops starts itself while busy
    assign div_start  = start_i & funct3_i[2];

    mult_unit u_mult (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .start_i     (mult_start),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .op_type_i   (funct3_i[1:0]),
        .result_o    (mult_result),
        .done_o      (mult_done)
    );

    div_unit u_div (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .start_i     (div_start),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .op_type_i   (funct3_i[1:0]),
        .result_o    (div_result),
        .done_o      (div_done),
        .busy_o      (div_busy)
    );

    ////////////////////
    // Result merge
    ////////////////////

    // Remembers which unit finished last so result_o holds between dones
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            last_div_q <= 1'b0;
        end else if (div_done || mult_done) begin
            last_div_q <= div_done;
        end
    end

    // Units never finish in the same cycle
    assign result_o = (div_done || (last_div_q && !mult_done)) ? div_result : mult_result;
    assign done_o   = mult_done | div_done;
    assign busy_o   = div_busy;

endmodule : muldiv_unit

// ==== testbench/muldiv_unit_tb.sv ====
// Self-checking muldiv_unit testbench; 40 ns clock, one request at a time except multiply bursts

`timescale 1ns/1ps

module muldiv_unit_tb
    import riscv_core_pkg::*;
;

    localparam int MUL_LAT = MUL_LATENCY;
    localparam int DIV_LAT = DIV_LATENCY;
    // Operation counts per kind summed over all tests
    localparam int N_MUL = 96 + 8;
    localparam int N_DIV = 24 + 16 + 2;
    localparam int WATCHDOG_CYCLES = N_MUL * (MUL_LAT + 3) + N_DIV * (DIV_LAT + 3) + 200;

    logic   clk_i = 1'b0;
    logic   rst_ni;
    logic   start_i;
    md_op_e funct3_i;
    word_t  operand_a_i;
    word_t  operand_b_i;
    word_t  result_o;
    logic   done_o;
    logic   busy_o;

    integer seed = 17;
    int     cyc = 0;
    int     n_pass = 0;
    int     n_fail = 0;
    bit     started = 1'b0;
    // Cycles in which the divider must report busy
    int     div_from = 1;
    int     div_to = -1;
    // Value that result_o must hold between done pulses
    word_t  last_res = '0;
    word_t  exp_res_q[$];
    int     exp_cyc_q[$];
    word_t  edge_vals[4] = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h8000_0000};

    muldiv_unit u_muldiv_unit (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .start_i     (start_i),
        .funct3_i    (funct3_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .result_o    (result_o),
        .done_o      (done_o),
        .busy_o      (busy_o)
    );

    always #20 clk_i = ~clk_i;

    always @(posedge clk_i) cyc <= cyc + 1;

    ////////////////////
    // Reference model
    ////////////////////

    // RV32M result from 64-bit arithmetic
    function automatic word_t ref_result(input md_op_e op, input word_t a, input word_t b);
        logic        [63:0] p;
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] q;
        logic signed [63:0] r;
        logic               ovf;
        sa  = {{32{a[31]}}, a};
        sb  = {{32{b[31]}}, b};
        ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        case (op)
            MD_MUL:    p = {32'b0, a} * {32'b0, b};
            MD_MULH:   p = sa * sb;
            // Sign-extended a times zero-extended b is exact modulo 2^64
            MD_MULHSU: p = sa * {32'b0, b};
            MD_MULHU:  p = {32'b0, a} * {32'b0, b};
            default:   p = '0;
        endcase
        if (b == '0) begin
            q = '1;
            r = sa;
        end else if (ovf) begin
            q = sa;
            r = '0;
        end else begin
            q = sa / sb;
            r = sa % sb;
        end
        case (op)
            MD_MUL:  return p[31:0];
            MD_DIV:  return q[31:0];
            MD_REM:  return r[31:0];
            MD_DIVU: return (b == '0) ? 32'hffff_ffff : a / b;
            MD_REMU: return (b == '0) ? a : a % b;
            default: return p[63:32];
        endcase
    endfunction

    // Busy window of the last accepted divide
    function automatic bit busy_due(input int c);
        return (c >= div_from) && (c <= div_to);
    endfunction

    ////////////////////
    // Monitor
    ////////////////////

    // Outputs settle at the rising edge and are sampled half a cycle later
    always @(negedge clk_i) begin
        if (rst_ni) begin
            if (!started) begin
                assert (!done_o && !busy_o && (result_o == '0)) n_pass++;
                else begin
                    $display("error reset state done_o %h busy_o %h result_o %h",
                             done_o, busy_o, result_o);
                    n_fail++;
                end
            end
            assert (busy_o == busy_due(cyc)) n_pass++;
            else begin
                $display("error busy_o expected %h got %h at cycle %0d",
                         busy_due(cyc), busy_o, cyc);
                n_fail++;
            end
            if (done_o) begin
                last_res = result_o;
                assert ((exp_cyc_q.size() != 0) && (exp_cyc_q[0] == cyc)) n_pass++;
                else begin
                    $display("done pulse at cycle %0d where no result was due", cyc);
                    n_fail++;
                end
                if ((exp_cyc_q.size() != 0) && (exp_cyc_q[0] == cyc)) begin
                    assert (result_o == exp_res_q[0]) n_pass++;
                    else begin
                        $display("error result_o expected %h got %h", exp_res_q[0], result_o);
                        n_fail++;
                    end
                    void'(exp_res_q.pop_front());
                    void'(exp_cyc_q.pop_front());
                end
            end else begin
                // Result holds its last value between done pulses
                assert (result_o == last_res) n_pass++;
                else begin
                    $display("error result_o expected %h got %h between done pulses",
                             last_res, result_o);
                    n_fail++;
                end
                if (exp_cyc_q.size() != 0) begin
                    assert (exp_cyc_q[0] > cyc) n_pass++;
                    else begin
                        $display("no done pulse in cycle %0d where a result was due", cyc);
                        n_fail++;
                        void'(exp_res_q.pop_front());
                        void'(exp_cyc_q.pop_front());
                    end
                end
            end
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    // Drive one start and expect a result only if the divider is idle
    task automatic issue(input md_op_e op, input word_t a, input word_t b);
        @(posedge clk_i);
        #2;
        start_i     = 1'b1;
        funct3_i    = op;
        operand_a_i = a;
        operand_b_i = b;
        started     = 1'b1;
        if (!busy_due(cyc)) begin
            exp_res_q.push_back(ref_result(op, a, b));
            if (op[2]) begin
                exp_cyc_q.push_back(cyc + DIV_LAT);
                div_from = cyc + 1;
                div_to   = cyc + DIV_LAT;
            end else begin
                exp_cyc_q.push_back(cyc + MUL_LAT);
            end
        end
    endtask

    // Drop start and wait out every pending result
    task automatic drain();
        @(posedge clk_i);
        #2;
        start_i = 1'b0;
        while ((exp_cyc_q.size() != 0) || (cyc <= div_to + 1)) @(posedge clk_i);
    endtask

    task automatic report(input string name, input int fail_mark);
        $display("test %s: %0d failing checks", name, n_fail - fail_mark);
    endtask

    task automatic random_ops(input int first, input int count, input bit wait_each);
        logic [31:0] a;
        logic [31:0] b;
        for (int i = 0; i < count; i++) begin
            a = $random(seed);
            b = $random(seed);
            issue(md_op_e'(3'(first + (i % 4))), a, b);
            if (wait_each) drain();
        end
    endtask

    initial begin : main
        int          mark;
        logic [31:0] rnd;
        rst_ni      = 1'b0;
        start_i     = 1'b0;
        funct3_i    = MD_MUL;
        operand_a_i = '0;
        operand_b_i = '0;
        repeat (2) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;
        // Outputs stay idle before any start
        mark = n_fail;
        repeat (3) @(posedge clk_i);
        report("reset", mark);
        // Multiplies on edge pairs then random operands
        mark = n_fail;
        for (int op = 0; op < 4; op++) begin
            for (int i = 0; i < 16; i++) begin
                issue(md_op_e'(3'(op)), edge_vals[i / 4], edge_vals[i % 4]);
                drain();
            end
        end
        random_ops(0, 32, 1'b1);
        report("multiply", mark);
        // Back-to-back multiplies with two in flight
        mark = n_fail;
        random_ops(0, 8, 1'b0);
        drain();
        report("multiply pipeline", mark);
        // Random divides
        mark = n_fail;
        random_ops(4, 24, 1'b1);
        report("divide", mark);
        // Divide by zero and signed overflow
        mark = n_fail;
        for (int op = 4; op < 8; op++) begin
            rnd = $random(seed);
            issue(md_op_e'(3'(op)), rnd, 32'h0);
            drain();
            issue(md_op_e'(3'(op)), 32'h0, 32'h0);
            drain();
            issue(md_op_e'(3'(op)), 32'h8000_0000, 32'hffff_ffff);
            drain();
            issue(md_op_e'(3'(op)), 32'h8000_0000, 32'h0);
            drain();
        end
        report("divide special cases", mark);
        // Starts while busy are dropped up to the done cycle
        mark = n_fail;
        for (int run = 0; run < 2; run++) begin
            rnd = $random(seed);
            issue(run ? MD_REMU : MD_DIV, rnd, 32'h0000_0007 + run);
            for (int k = 0; k < DIV_LAT; k++) begin
                rnd = $random(seed);
                issue(md_op_e'(rnd[2:0]), $random(seed), $random(seed));
            end
            drain();
        end
        report("starts while busy", mark);
        $display("checks passed %0d failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog sized from the operation counts above
    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule : muldiv_unit_tb

// ==== compile.f ====
verilog/riscv_core_pkg.sv
verilog/mult_unit.sv
verilog/div_unit.sv
verilog/muldiv_unit.sv
testbench/muldiv_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the muldiv_unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f compile.f \
    --top-module muldiv_unit_tb \
    -Mdir obj_dir \
    && ./obj_dir/Vmuldiv_unit_tb | tee /dev/stderr | grep -qx "TEST PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
